// ==== src/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t; // Register, ALU and memory word.
	typedef logic [15:0] instr_t;
	typedef logic [2:0] reg_idx_t;
	typedef logic signed [5:0] imm_t; // Offset for ADDI, LOAD, STORE and BEQ.

	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_OR = 4'd3,
		OP_XOR = 4'd4,
		OP_ADDI = 4'd5,
		OP_LOAD = 4'd6,
		OP_STORE = 4'd7,
		OP_BEQ = 4'd8,
		OP_JMP = 4'd9,
		OP_HALT = 4'd10
	} opcode_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_XOR = 3'd4
	} alu_op_t;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	typedef logic [15:0] addr_t; // Word address, not byte address.

	// Only the low bits are decoded, so memory wraps.
	localparam int ADDR_WIDTH_DEFAULT = 10;

endpackage

`default_nettype wire

// ==== src/memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory
#(
	parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH_DEFAULT
)
(
	input wire clock,
	input wire mem_pkg::addr_t fetch_addr,
	input wire data_we,
	input wire mem_pkg::addr_t data_addr,
	input wire isa_pkg::word_t data_wdata,
	output isa_pkg::instr_t instr,
	output isa_pkg::word_t data_rdata
);

	isa_pkg::word_t ram [0:(2**ADDR_WIDTH)-1];

	logic [ADDR_WIDTH-1:0] fetch_index;
	logic [ADDR_WIDTH-1:0] data_index;

	assign fetch_index = fetch_addr[ADDR_WIDTH-1:0]; // Upper bits ignored.
	assign data_index = data_addr[ADDR_WIDTH-1:0];

	// Instruction is the low half of the fetched word.
	always_ff @(posedge clock)
	begin
		instr <= ram[fetch_index][15:0];
	end

	always_ff @(posedge clock)
	begin
		if (data_we)
		begin
			ram[data_index] <= data_wdata;
		end
		data_rdata <= ram[data_index]; // Old value on a same-cycle write.
	end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file
(
	input wire clock,
	input wire rst,
	input wire isa_pkg::reg_idx_t ra_idx,
	input wire isa_pkg::reg_idx_t rb_idx,
	input wire we,
	input wire isa_pkg::reg_idx_t wr_idx,
	input wire isa_pkg::word_t wdata,
	output isa_pkg::word_t ra_data,
	output isa_pkg::word_t rb_data
);

	isa_pkg::word_t regs [0:7];

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && (wr_idx != 3'd0))
		begin
			regs[wr_idx] <= wdata; // r0 is never written.
		end
	end

	assign ra_data = (ra_idx == 3'd0) ? '0 : regs[ra_idx];
	assign rb_data = (rb_idx == 3'd0) ? '0 : regs[rb_idx];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
(
	input wire isa_pkg::word_t a,
	input wire isa_pkg::word_t b,
	input wire isa_pkg::alu_op_t op,
	output isa_pkg::word_t result,
	output logic equal
);

	always_comb
	begin
		case (op)
			isa_pkg::ALU_ADD:
				result = a + b; // Wraps at 32 bits.
			isa_pkg::ALU_SUB:
				result = a - b;
			isa_pkg::ALU_AND:
				result = a & b;
			isa_pkg::ALU_OR:
				result = a | b;
			isa_pkg::ALU_XOR:
				result = a ^ b;
			default:
				result = '0;
		endcase
	end

	assign equal = (a == b); // Branch condition for BEQ.

endmodule

`default_nettype wire

// ==== src/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit
(
	input wire clock,
	input wire rst,
	input wire start,
	input wire isa_pkg::instr_t instr,
	input wire isa_pkg::word_t ra_data,
	input wire isa_pkg::word_t rb_data,
	input wire isa_pkg::word_t alu_result,
	input wire equal,
	input wire isa_pkg::word_t mem_rdata,
	output mem_pkg::addr_t fetch_addr,
	output isa_pkg::reg_idx_t ra_idx,
	output isa_pkg::reg_idx_t rb_idx,
	output logic rf_we,
	output isa_pkg::reg_idx_t wr_idx,
	output isa_pkg::word_t rf_wdata,
	output isa_pkg::word_t alu_a,
	output isa_pkg::word_t alu_b,
	output isa_pkg::alu_op_t alu_op,
	output logic mem_we,
	output mem_pkg::addr_t mem_addr,
	output isa_pkg::word_t mem_wdata,
	output logic running,
	output logic halted
);

	typedef enum logic [2:0] {IDLE, FETCH, EXECUTE, MEM, WRITEBACK, HALT_S} state_t;

	state_t state;
	state_t next_state;
	mem_pkg::addr_t pc;
	mem_pkg::addr_t next_pc;
	mem_pkg::addr_t pc_inc;
	isa_pkg::opcode_t opcode;
	isa_pkg::imm_t imm;
	isa_pkg::word_t imm_ext;
	logic reg_form;
	logic use_rb;

	assign opcode = isa_pkg::opcode_t'(instr[15:12]);
	assign imm = instr[5:0];
	assign imm_ext = {{26{imm[5]}}, imm};
	assign reg_form = (opcode inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
		isa_pkg::OP_OR, isa_pkg::OP_XOR});
	assign use_rb = reg_form || (opcode == isa_pkg::OP_BEQ); // BEQ compares rs with rd.
	assign pc_inc = pc + 16'd1;

	// Instruction stays valid in MEM and WRITEBACK since pc is held.
	assign fetch_addr = pc;
	assign ra_idx = instr[8:6];
	assign rb_idx = reg_form ? instr[5:3] : instr[11:9];
	assign alu_a = ra_data;
	assign alu_b = use_rb ? rb_data : imm_ext;

	always_comb
	begin
		case (opcode)
			isa_pkg::OP_SUB: alu_op = isa_pkg::ALU_SUB;
			isa_pkg::OP_AND: alu_op = isa_pkg::ALU_AND;
			isa_pkg::OP_OR: alu_op = isa_pkg::ALU_OR;
			isa_pkg::OP_XOR: alu_op = isa_pkg::ALU_XOR;
			default: alu_op = isa_pkg::ALU_ADD; // Also forms rs + imm.
		endcase
	end

	assign mem_addr = alu_result[15:0];
	assign mem_wdata = rb_data;
	assign mem_we = (state == MEM) && (opcode == isa_pkg::OP_STORE);

	assign wr_idx = instr[11:9];
	assign rf_wdata = (state == WRITEBACK) ? mem_rdata : alu_result;
	assign rf_we = ((state == EXECUTE) && (reg_form || (opcode == isa_pkg::OP_ADDI)))
		|| (state == WRITEBACK);

	assign running = (state != IDLE) && (state != HALT_S);
	assign halted = (state == HALT_S);

	always_comb
	begin
		next_state = state;
		next_pc = pc;
		case (state)
			IDLE, HALT_S:
				if (start)
				begin
					next_state = FETCH;
					next_pc = '0;
				end
			FETCH:
				next_state = EXECUTE;
			EXECUTE:
			begin
				next_state = FETCH;
				case (opcode)
					isa_pkg::OP_LOAD, isa_pkg::OP_STORE:
						next_state = MEM;
					isa_pkg::OP_HALT:
						next_state = HALT_S;
					isa_pkg::OP_BEQ:
						next_pc = equal ? (pc_inc + imm_ext[15:0]) : pc_inc;
					isa_pkg::OP_JMP:
						next_pc = {4'd0, instr[11:0]}; // Absolute target.
					default:
						next_pc = pc_inc;
				endcase
			end
			MEM:
				if (opcode == isa_pkg::OP_STORE)
				begin
					next_state = FETCH;
					next_pc = pc_inc;
				end
				else
				begin
					next_state = WRITEBACK;
				end
			WRITEBACK:
			begin
				next_state = FETCH;
				next_pc = pc_inc;
			end
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= IDLE;
			pc <= '0;
		end
		else
		begin
			state <= next_state;
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== src/host_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module host_port
#(
	parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH_DEFAULT
)
(
	input wire clock,
	input wire rst,
	input wire running,
	input wire host_req,
	input wire host_we,
	input wire mem_pkg::addr_t host_addr,
	input wire isa_pkg::word_t host_wdata,
	input wire core_we,
	input wire mem_pkg::addr_t core_addr,
	input wire isa_pkg::word_t core_wdata,
	input wire isa_pkg::word_t mem_rdata,
	output logic host_ack,
	output isa_pkg::word_t host_rdata,
	output logic data_we,
	output mem_pkg::addr_t data_addr,
	output isa_pkg::word_t data_wdata
);

	typedef enum logic [1:0] {IDLE, ISSUE, ACK, WAIT_LOW} state_t;

	localparam mem_pkg::addr_t ADDR_MASK = mem_pkg::addr_t'((32'd1 << ADDR_WIDTH) - 32'd1);

	state_t state;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= IDLE;
			host_ack <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (host_req && !running) // Held off while the core runs.
					begin
						state <= ISSUE;
					end
				ISSUE:
					state <= ACK;
				ACK:
				begin
					state <= WAIT_LOW;
					host_ack <= 1'b1;
				end
				WAIT_LOW:
					if (!host_req)
					begin
						state <= IDLE;
						host_ack <= 1'b0;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (state == ACK)
		begin
			host_rdata <= mem_rdata;
		end
	end

	// Core owns the data port while running.
	assign data_we = running ? core_we : ((state == ISSUE) && host_we);
	assign data_addr = running ? core_addr : (host_addr & ADDR_MASK);
	assign data_wdata = running ? core_wdata : host_wdata;

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top
#(
	parameter int ADDR_WIDTH = mem_pkg::ADDR_WIDTH_DEFAULT
)
(
	input wire clock,
	input wire rst,
	input wire start,
	output logic running,
	output logic halted,
	input wire host_req,
	input wire host_we,
	input wire mem_pkg::addr_t host_addr,
	input wire isa_pkg::word_t host_wdata,
	output logic host_ack,
	output isa_pkg::word_t host_rdata
);

	mem_pkg::addr_t fetch_addr;
	isa_pkg::instr_t instr;
	logic data_we;
	mem_pkg::addr_t data_addr;
	isa_pkg::word_t data_wdata;
	isa_pkg::word_t data_rdata;
	logic core_mem_we;
	mem_pkg::addr_t core_mem_addr;
	isa_pkg::word_t core_mem_wdata;
	isa_pkg::reg_idx_t ra_idx;
	isa_pkg::reg_idx_t rb_idx;
	isa_pkg::reg_idx_t wr_idx;
	logic rf_we;
	isa_pkg::word_t rf_wdata;
	isa_pkg::word_t ra_data;
	isa_pkg::word_t rb_data;
	isa_pkg::word_t alu_a;
	isa_pkg::word_t alu_b;
	isa_pkg::alu_op_t alu_op;
	isa_pkg::word_t alu_result;
	logic equal;

	memory #(.ADDR_WIDTH(ADDR_WIDTH)) memory0 (
		.clock(clock), .fetch_addr(fetch_addr), .data_we(data_we), .data_addr(data_addr),
		.data_wdata(data_wdata), .instr(instr), .data_rdata(data_rdata)
	);

	register_file register_file0 (
		.clock(clock), .rst(rst), .ra_idx(ra_idx), .rb_idx(rb_idx), .we(rf_we),
		.wr_idx(wr_idx), .wdata(rf_wdata), .ra_data(ra_data), .rb_data(rb_data)
	);

	alu alu0 (
		.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .equal(equal)
	);

	control_unit control_unit0 (
		.clock(clock), .rst(rst), .start(start), .instr(instr), .ra_data(ra_data),
		.rb_data(rb_data), .alu_result(alu_result), .equal(equal), .mem_rdata(data_rdata),
		.fetch_addr(fetch_addr), .ra_idx(ra_idx), .rb_idx(rb_idx), .rf_we(rf_we),
		.wr_idx(wr_idx), .rf_wdata(rf_wdata), .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op),
		.mem_we(core_mem_we), .mem_addr(core_mem_addr), .mem_wdata(core_mem_wdata),
		.running(running), .halted(halted)
	);

	host_port #(.ADDR_WIDTH(ADDR_WIDTH)) host_port0 (
		.clock(clock), .rst(rst), .running(running), .host_req(host_req),
		.host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
		.core_we(core_mem_we), .core_addr(core_mem_addr), .core_wdata(core_mem_wdata),
		.mem_rdata(data_rdata), .host_ack(host_ack), .host_rdata(host_rdata),
		.data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata)
	);

endmodule

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

	localparam int ADDR_WIDTH = 10;
	localparam mem_pkg::addr_t ADDR_MASK = mem_pkg::addr_t'((1 << ADDR_WIDTH) - 1);
	localparam int BASE_SLOT = 30; // Word holding the data base pointer.
	localparam int MODEL_STEP_LIMIT = 100000;
	localparam int PROGRAM_INSTRS = 64;
	localparam int HOST_ACCESSES = 160;
	localparam int WATCHDOG_CYCLES = 16 + 200 * PROGRAM_INSTRS + 10 * HOST_ACCESSES;

	logic clock;
	logic rst;
	logic start;
	logic running;
	logic halted;
	logic host_req;
	logic host_we;
	mem_pkg::addr_t host_addr;
	isa_pkg::word_t host_wdata;
	logic host_ack;
	isa_pkg::word_t host_rdata;

	integer seed;
	int error_count;
	int check_count;
	logic halted_at_ack;
	isa_pkg::word_t model_mem [0:(2**ADDR_WIDTH)-1]; // Mirror of DUT memory.
	isa_pkg::word_t model_regs [0:7];
	isa_pkg::instr_t prog [$];

	cpu_top #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (
		.clock(clock), .rst(rst), .start(start), .running(running), .halted(halted),
		.host_req(host_req), .host_we(host_we), .host_addr(host_addr),
		.host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata)
	);

	initial
	begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("Watchdog expired after %0d cycles, the core never halted", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	function automatic isa_pkg::instr_t enc_reg(isa_pkg::opcode_t op, int rd, int rs, int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
	endfunction

	function automatic isa_pkg::instr_t enc_imm(isa_pkg::opcode_t op, int rd, int rs, int imm);
		return {op, rd[2:0], rs[2:0], imm[5:0]};
	endfunction

	function automatic isa_pkg::instr_t enc_jmp(int target);
		return {isa_pkg::OP_JMP, target[11:0]};
	endfunction

	function automatic void set_reg(isa_pkg::reg_idx_t idx, isa_pkg::word_t value);
		if (idx != 3'd0)
			model_regs[idx] = value; // r0 stays zero.
	endfunction

	// Runs the program in model_mem from address 0, returns steps to HALT or -1.
	function automatic int run_model();
		mem_pkg::addr_t pc;
		isa_pkg::instr_t ins;
		isa_pkg::reg_idx_t rd;
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		isa_pkg::word_t imm_w;
		isa_pkg::word_t ea;
		pc = '0;
		for (int steps = 1; steps <= MODEL_STEP_LIMIT; steps++)
		begin
			ins = model_mem[pc[ADDR_WIDTH-1:0]][15:0];
			rd = ins[11:9];
			a = model_regs[ins[8:6]];
			b = model_regs[ins[5:3]];
			imm_w = {{26{ins[5]}}, ins[5:0]};
			ea = a + imm_w;
			pc = pc + 16'd1;
			case (isa_pkg::opcode_t'(ins[15:12]))
				isa_pkg::OP_ADD: set_reg(rd, a + b);
				isa_pkg::OP_SUB: set_reg(rd, a - b);
				isa_pkg::OP_AND: set_reg(rd, a & b);
				isa_pkg::OP_OR: set_reg(rd, a | b);
				isa_pkg::OP_XOR: set_reg(rd, a ^ b);
				isa_pkg::OP_ADDI: set_reg(rd, a + imm_w);
				isa_pkg::OP_LOAD: set_reg(rd, model_mem[ea[ADDR_WIDTH-1:0]]);
				isa_pkg::OP_STORE: model_mem[ea[ADDR_WIDTH-1:0]] = model_regs[rd];
				isa_pkg::OP_BEQ:
					if (model_regs[rd] == a)
						pc = pc + imm_w[15:0];
				isa_pkg::OP_JMP: pc = {4'd0, ins[11:0]};
				isa_pkg::OP_HALT: return steps;
				default: ;
			endcase
		end
		return -1;
	endfunction

	task automatic check_word(input string name, input isa_pkg::word_t expected,
		input isa_pkg::word_t actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_halted(input string name, input bit expected, input bit actual);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("Fail %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic host_write(input mem_pkg::addr_t addr, input isa_pkg::word_t data);
		@(negedge clock);
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		host_req = 1'b1;
		while (!host_ack) @(negedge clock);
		host_req = 1'b0;
		host_we = 1'b0;
		while (host_ack) @(negedge clock);
		model_mem[addr[ADDR_WIDTH-1:0]] = data; // Upper address bits alias.
	endtask

	task automatic host_read(input mem_pkg::addr_t addr, output isa_pkg::word_t data);
		@(negedge clock);
		host_we = 1'b0;
		host_addr = addr;
		host_req = 1'b1;
		while (!host_ack) @(negedge clock);
		data = host_rdata;
		halted_at_ack = halted;
		host_req = 1'b0;
		while (host_ack) @(negedge clock);
	endtask

	task automatic read_and_check(input string name, input mem_pkg::addr_t addr);
		isa_pkg::word_t got;
		host_read(addr, got);
		check_word(name, model_mem[addr[ADDR_WIDTH-1:0]], got);
	endtask

	task automatic load_program(input mem_pkg::addr_t base);
		foreach (prog[i])
			host_write(mem_pkg::addr_t'(i), {16'h0000, prog[i]});
		host_write(mem_pkg::addr_t'(BASE_SLOT), {16'h0000, base});
	endtask

	task automatic start_core(input string name);
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		check_halted({name, " running after start"}, 1'b1, running);
		check_halted({name, " halted cleared by start"}, 1'b0, halted);
	endtask

	task automatic finish_program(input string name);
		while (!halted) @(negedge clock);
		check_halted({name, " running after HALT"}, 1'b0, running);
		if (run_model() < 0)
		begin
			error_count++;
			$display("Reference model for %s never reached HALT", name);
		end
	endtask

	task automatic test_host_access();
		mem_pkg::addr_t addr;
		mem_pkg::addr_t alias_addr;
		isa_pkg::word_t data;
		isa_pkg::word_t got;
		for (int i = 0; i < 12; i++)
		begin
			addr = mem_pkg::addr_t'($random(seed)) & ADDR_MASK;
			data = $random(seed);
			alias_addr = addr | (mem_pkg::addr_t'($random(seed)) & ~ADDR_MASK) | (ADDR_MASK + 1);
			host_write((i < 8) ? addr : alias_addr, data); // Last four go through an alias.
			host_read(addr, got);
			check_word((i < 8) ? "host write then read" : "aliased host write", data, got);
		end
	endtask

	task automatic test_alu(input mem_pkg::addr_t base);
		isa_pkg::opcode_t ops [5] = '{isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
			isa_pkg::OP_OR, isa_pkg::OP_XOR};
		isa_pkg::word_t got;
		host_write(base, $random(seed));
		host_write(base + 16'd1, $random(seed));
		host_write(base + 16'd8, $random(seed) | 32'd1); // Nonzero before r0 is stored.
		prog.delete();
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 7, 0, BASE_SLOT));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 1, 7, 0));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 2, 7, 1));
		for (int i = 0; i < 5; i++)
		begin
			prog.push_back(enc_reg(ops[i], 3, 1, 2));
			prog.push_back(enc_imm(isa_pkg::OP_STORE, 3, 7, 2 + i));
		end
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 3, 1, -7));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 3, 7, 7));
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 0, 1, 5));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 0, 7, 8));
		prog.push_back({isa_pkg::OP_HALT, 12'd0});
		load_program(base);
		start_core("alu");
		finish_program("alu");
		for (int off = 2; off <= 7; off++)
			read_and_check($sformatf("alu result %0d", off), base + mem_pkg::addr_t'(off));
		host_read(base + 16'd8, got);
		check_word("store of r0", 32'd0, got);
	endtask

	task automatic test_load_store(input mem_pkg::addr_t base);
		int offs [5] = '{-5, 31, -32, 19, 0};
		for (int i = 0; i < 4; i++)
			host_write(base + mem_pkg::addr_t'(i), $random(seed));
		prog.delete();
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 7, 0, BASE_SLOT));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 1, 7, 0));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 1, 7, -5));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 2, 7, 1));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 2, 7, 31));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 3, 7, -5)); // Reads back the first copy.
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 3, 7, -32));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 4, 7, 2));
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 5, 7, 20));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 4, 5, -1));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 6, 7, 3));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 6, 5, -20));
		prog.push_back({isa_pkg::OP_HALT, 12'd0});
		load_program(base);
		start_core("load store");
		finish_program("load store");
		foreach (offs[i])
			read_and_check($sformatf("copy at offset %0d", offs[i]),
				mem_pkg::addr_t'(int'(base) + offs[i]));
	endtask

	task automatic test_control_flow(input mem_pkg::addr_t base);
		isa_pkg::word_t poison;
		isa_pkg::word_t got;
		poison = $random(seed);
		host_write(base, ($random(seed) & 32'h7) + 32'd3); // Loop count.
		host_write(base + 16'd1, $random(seed));
		host_write(base + 16'd2, poison);
		host_write(base + 16'd3, $random(seed));
		prog.delete();
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 7, 0, BASE_SLOT));
		prog.push_back(enc_imm(isa_pkg::OP_LOAD, 2, 7, 0));
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 1, 0, 0));
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 3, 0, 0));
		prog.push_back(enc_imm(isa_pkg::OP_BEQ, 1, 2, 3)); // Exits to 8 when done.
		prog.push_back(enc_imm(isa_pkg::OP_ADDI, 1, 1, 1));
		prog.push_back(enc_reg(isa_pkg::OP_ADD, 3, 3, 1));
		prog.push_back(enc_jmp(4));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 1, 7, 1));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 3, 7, 3));
		prog.push_back(enc_jmp(12));
		prog.push_back(enc_imm(isa_pkg::OP_STORE, 2, 7, 2)); // Skipped.
		prog.push_back({isa_pkg::OP_HALT, 12'd0});
		load_program(base);
		start_core("control flow");
		host_read(base + 16'd2, got); // Must wait for the core to halt.
		check_halted("host ack held off while running", 1'b1, halted_at_ack);
		finish_program("control flow");
		check_word("poisoned address", poison, got);
		read_and_check("loop counter", base + 16'd1);
		read_and_check("loop sum", base + 16'd3);
	endtask

	initial
	begin
		seed = 32069;
		error_count = 0;
		check_count = 0;
		halted_at_ack = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		for (int i = 0; i < 8; i++)
			model_regs[i] = '0;
		repeat (16) @(negedge clock);
		rst = 1'b0;
		test_host_access();
		test_alu(16'h0100);
		test_load_store(16'h0200);
		test_control_flow(16'h0300);
		test_alu(16'h0140); // Restart with a fresh program.
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
src/isa_pkg.sv
src/mem_pkg.sv
src/memory.sv
src/register_file.sv
src/alu.sv
src/control_unit.sv
src/host_port.sv
src/cpu_top.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compiles and runs the CPU testbench with Verilator, then checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module cpu_tb -o cpu_tb_sim \
	&& ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete"
[ -f sim.log ] && cat sim.log
grep -qx "Simulation passed" sim.log && { echo "PASS"; exit 0; } || { echo "FAIL"; exit 1; }
